//--- bench/data_mem_ref.svh
// Reference model for the data memory testbench
// Galois LFSR random source, word model and expected response function
`ifndef DATA_MEM_REF_SVH
`define DATA_MEM_REF_SVH

logic [15:0] lfsr_state = 16'd29;
logic [31:0] ref_mem [WORDS];  // Expected RAM contents, one word per entry

// Right-shifting Galois LFSR, taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Collects n random bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

// Expected response for one accepted request
// Aligned stores also update the model
function automatic mem_pkg::mem_rsp_t ref_access(input mem_pkg::mem_req_t r);
   mem_pkg::mem_rsp_t rsp_exp;
   int                nbytes;
   int                off;
   int                widx;
   logic              is_store;
   logic              sign_ext;
   logic [31:0]       val;
   rsp_exp       = '0;
   rsp_exp.valid = 1'b1;
   nbytes        = 4;
   is_store      = r.op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw};
   sign_ext      = r.op inside {mem_pkg::op_lb, mem_pkg::op_lh};
   if (r.op inside {mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_sb}) begin
      nbytes = 1;
   end else if (r.op inside {mem_pkg::op_lh, mem_pkg::op_lhu, mem_pkg::op_sh}) begin
      nbytes = 2;
   end
   off  = int'(r.addr[1:0]);
   widx = int'(r.addr[ADDR_W+1:2]);
   if ((off % nbytes) != 0) begin
      rsp_exp.misaligned = 1'b1;  // Nothing written, rdata stays zero
      return rsp_exp;
   end
   if (is_store) begin
      for (int i = 0; i < nbytes; i++) begin
         ref_mem[widx][8*(off+i) +: 8] = r.wdata[8*i +: 8];  // Byte i to lane off+i
      end
      return rsp_exp;
   end
   val = '0;
   for (int i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = ref_mem[widx][8*(off+i) +: 8];
   end
   for (int i = 8 * nbytes; i < 32; i++) begin
      val[i] = sign_ext & val[8*nbytes-1];
   end
   rsp_exp.rdata = val;
   return rsp_exp;
endfunction

`endif

//--- bench/data_mem_tb.sv
// Testbench for the data memory block
// Clock, reset, stimulus phases, response checks, watchdog and report
module data_mem_tb;

   localparam int ADDR_W    = 6;
   localparam int WORDS     = 2 ** ADDR_W;
   localparam int PERIOD    = 100;
   localparam int N_SUB     = 48;   // Random byte and halfword stores
   localparam int EXT_WORDS = 8;
   localparam int MIS_WORDS = 8;
   localparam int N_RAND    = 300;
   // Reset, idles and every driven cycle of all phases
   localparam int TEST_CYCLES = 5 + 4 + 2 * WORDS + N_SUB + WORDS + EXT_WORDS * 13 +
                                MIS_WORDS * 11 + N_RAND + 3;
   localparam mem_pkg::mem_rsp_t IDLE_RSP = '0;

   logic              clk;
   logic              reset;
   logic              req_valid;
   mem_pkg::mem_req_t req;
   mem_pkg::mem_rsp_t rsp;

   mem_pkg::mem_rsp_t exp_q [$];  // Expected responses, oldest first
   int                mismatch_errs = 0;
   int                pulse_errs    = 0;

   `include "data_mem_ref.svh"

   data_mem #(
      .ADDR_W (ADDR_W)
   ) u_dut (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .rsp       (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   function automatic mem_pkg::mem_req_t make_req(input mem_pkg::mem_op_t op,
                                                  input logic [31:0] addr,
                                                  input logic [31:0] wdata);
      mem_pkg::mem_req_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      return r;
   endfunction

   // One request slot, expected response queued with it
   task automatic drive_cycle(input logic v, input mem_pkg::mem_req_t r);
      @(posedge clk);
      #10;
      req_valid = v;
      req       = r;
      if (v) begin
         exp_q.push_back(ref_access(r));
      end else begin
         exp_q.push_back(IDLE_RSP);
      end
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         drive_cycle(1'b0, make_req(mem_pkg::op_lw, '0, '0));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatch_errs++;
         $display("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_rsp(input mem_pkg::mem_rsp_t got, input mem_pkg::mem_rsp_t exp);
      if (got.valid !== exp.valid) begin
         pulse_errs++;
         if (exp.valid) begin
            $display("missing rsp.valid pulse one cycle after a request, time %0t", $time);
         end else begin
            $display("rsp.valid pulse without a request, time %0t", $time);
         end
      end
      check_flag("rsp.misaligned", got.misaligned, exp.misaligned);
      if (got.rdata !== exp.rdata) begin
         mismatch_errs++;
         $display("mismatch at %0t: rsp.rdata = 0x%08h, expected 0x%08h",
                  $time, got.rdata, exp.rdata);
      end
   endtask

   // rsp is stable at the falling edge, front entry is last cycle's request
   always @(negedge clk) begin
      if (exp_q.size() > 1) begin
         check_rsp(rsp, exp_q.pop_front());
      end
   end

   initial begin
      #((TEST_CYCLES + 20) * PERIOD);
      $display("watchdog expired after %0d cycles, run did not finish", TEST_CYCLES + 20);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      mem_pkg::mem_req_t r;
      logic [31:0]       t;
      logic [31:0]       d;
      logic [31:0]       a;
      logic              prev_store;
      logic [31:0]       prev_addr;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      prev_store = 1'b0;
      prev_addr  = '0;
      repeat (5) @(posedge clk);
      #10;
      reset = 1'b0;
      idle_cycles(4);  // rsp.valid must stay low here

      // Fill every word, then read it back
      for (int w = 0; w < WORDS; w++) begin
         drive_cycle(1'b1, make_req(mem_pkg::op_sw, w * 4, rand_bits(32)));
      end
      for (int w = 0; w < WORDS; w++) begin
         drive_cycle(1'b1, make_req(mem_pkg::op_lw, w * 4, '0));
      end

      // Sub-word stores, seen through whole-word loads
      for (int n = 0; n < N_SUB; n++) begin
         t = rand_bits(1);
         a = rand_bits(ADDR_W + 2);
         if (t[0]) begin
            a[0] = 1'b0;
            drive_cycle(1'b1, make_req(mem_pkg::op_sh, a, rand_bits(32)));
         end else begin
            drive_cycle(1'b1, make_req(mem_pkg::op_sb, a, rand_bits(32)));
         end
      end
      for (int w = 0; w < WORDS; w++) begin
         drive_cycle(1'b1, make_req(mem_pkg::op_lw, w * 4, '0));
      end

      // Extension at every legal offset, both signs per lane
      for (int w = 0; w < EXT_WORDS; w++) begin
         d = rand_bits(32);
         d = (w % 2 == 0) ? (d | 32'h8080_8080) : (d & 32'h7F7F_7F7F);
         drive_cycle(1'b1, make_req(mem_pkg::op_sw, w * 4, d));
         for (int off = 0; off < 4; off++) begin
            drive_cycle(1'b1, make_req(mem_pkg::op_lb, w * 4 + off, '0));
            drive_cycle(1'b1, make_req(mem_pkg::op_lbu, w * 4 + off, '0));
         end
         for (int off = 0; off < 4; off += 2) begin
            drive_cycle(1'b1, make_req(mem_pkg::op_lh, w * 4 + off, '0));
            drive_cycle(1'b1, make_req(mem_pkg::op_lhu, w * 4 + off, '0));
         end
      end

      // Misaligned accesses, then a word load to prove nothing was written
      for (int w = EXT_WORDS; w < EXT_WORDS + MIS_WORDS; w++) begin
         for (int off = 1; off < 4; off++) begin
            drive_cycle(1'b1, make_req(mem_pkg::op_sw, w * 4 + off, rand_bits(32)));
            drive_cycle(1'b1, make_req(mem_pkg::op_lw, w * 4 + off, '0));
         end
         for (int off = 1; off < 4; off += 2) begin
            drive_cycle(1'b1, make_req(mem_pkg::op_sh, w * 4 + off, rand_bits(32)));
            drive_cycle(1'b1, make_req((off == 1) ? mem_pkg::op_lh : mem_pkg::op_lhu,
                                       w * 4 + off, '0));
         end
         drive_cycle(1'b1, make_req(mem_pkg::op_lw, w * 4, '0));
      end

      // Random mix every cycle, stores often chased by a load of the same word
      for (int n = 0; n < N_RAND; n++) begin
         t = rand_bits(3);
         r = make_req(mem_pkg::mem_op_t'(t[2:0]), rand_bits(ADDR_W + 2), rand_bits(32));
         t = rand_bits(1);
         if (prev_store && t[0]) begin
            r = make_req(mem_pkg::op_lw, {prev_addr[31:2], 2'b00}, '0);
         end
         drive_cycle(1'b1, r);
         prev_store = r.op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw};
         prev_addr  = r.addr;
      end

      idle_cycles(3);
      @(negedge clk);
      #1;
      $display("errors: %0d value mismatches, %0d valid pulse errors",
               mismatch_errs, pulse_errs);
      if (mismatch_errs + pulse_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+bench
source/mem_pkg.sv
source/byte_col_ram.sv
source/sp_ram_be.sv
source/store_align.sv
source/load_extract.sv
source/data_mem.sv
bench/data_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the data memory testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module data_mem_tb \
   -o data_mem_sim \
   && ./obj_dir/data_mem_sim 2>&1 | tee sim.log \
   || echo "build or simulation did not complete"

# The log decides the result
grep -q "TESTS PASSED" sim.log && echo "run passed" && exit 0
echo "run failed"
exit 1

//--- source/byte_col_ram.sv
// Single byte column RAM, single port, read-first
module byte_col_ram #(
   parameter int ADDR_W = 10
) (
   input  logic                      clk,
   input  logic                      en,
   input  logic                      we,
   input  logic [ADDR_W-1:0]         addr,
   input  logic [mem_pkg::COL_W-1:0] din,
   output logic [mem_pkg::COL_W-1:0] dout
);

   localparam int DEPTH = 2 ** ADDR_W;

   // Storage for one byte lane
   logic [mem_pkg::COL_W-1:0] mem [DEPTH];

   // Old contents go out while the new byte goes in
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= din;
         end
         dout <= mem[addr]; // Holds while en is low
      end
   end

endmodule

//--- source/data_mem.sv
// Data memory top level
// Store aligner, byte-enabled RAM and load extractor
module data_mem #(
   parameter int ADDR_W = 10 // Word address bits, 2**ADDR_W words
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   input  mem_pkg::mem_req_t req,
   output mem_pkg::mem_rsp_t rsp
);

   logic                        ram_en;
   logic [mem_pkg::NUM_COL-1:0] ram_we;
   logic [ADDR_W-1:0]           ram_addr;
   logic [mem_pkg::DATA_W-1:0]  ram_din;
   logic [mem_pkg::DATA_W-1:0]  ram_dout;
   logic                        misaligned;

   // Request to word access, same cycle
   store_align #(
      .ADDR_W (ADDR_W)
   ) u_store_align (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .ram_en     (ram_en),
      .ram_we     (ram_we),
      .ram_addr   (ram_addr),
      .ram_din    (ram_din),
      .misaligned (misaligned)
   );

   // Read-first, so a store returns the old word on ram_dout
   sp_ram_be #(
      .ADDR_W (ADDR_W)
   ) u_ram (
      .clk  (clk),
      .en   (ram_en),
      .we   (ram_we),
      .addr (ram_addr),
      .din  (ram_din),
      .dout (ram_dout)
   );

   // Response lines up with ram_dout one cycle later
   load_extract u_load_extract (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .misaligned (misaligned),
      .ram_dout   (ram_dout),
      .rsp        (rsp)
   );

endmodule

//--- source/load_extract.sv
// Response former for the data RAM
// Load byte selection and sign or zero extension, one cycle after the request
module load_extract (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       req_valid,
   input  mem_pkg::mem_req_t          req,
   input  logic                       misaligned,
   input  logic [mem_pkg::DATA_W-1:0] ram_dout,
   output mem_pkg::mem_rsp_t          rsp
);

   logic              is_load;
   logic              valid_q;
   logic              load_q;    // Aligned load in flight
   logic              mis_q;
   mem_pkg::mem_op_t  op_q;
   logic [1:0]        off_q;
   logic [7:0]        byte_sel;
   logic [15:0]       half_sel;
   logic [mem_pkg::DATA_W-1:0] ext_data;

   assign is_load = (req.op != mem_pkg::op_sb) &&
                    (req.op != mem_pkg::op_sh) &&
                    (req.op != mem_pkg::op_sw);

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
         load_q  <= 1'b0;
         mis_q   <= 1'b0;
      end else begin
         valid_q <= req_valid;
         load_q  <= req_valid && is_load && !misaligned;
         mis_q   <= req_valid && misaligned;
      end
   end

   // Op and byte offset for the response cycle
   always_ff @(posedge clk) begin
      op_q  <= req.op;
      off_q <= req.addr[1:0];
   end

   // Lane k for byte offset k
   always_comb begin
      case (off_q)
         2'd0:    byte_sel = ram_dout[7:0];
         2'd1:    byte_sel = ram_dout[15:8];
         2'd2:    byte_sel = ram_dout[23:16];
         default: byte_sel = ram_dout[31:24];
      endcase
   end

   assign half_sel = off_q[1] ? ram_dout[31:16] : ram_dout[15:0];

   always_comb begin
      case (op_q)
         mem_pkg::op_lb:  ext_data = {{24{byte_sel[7]}}, byte_sel};
         mem_pkg::op_lbu: ext_data = {24'd0, byte_sel};
         mem_pkg::op_lh:  ext_data = {{16{half_sel[15]}}, half_sel};
         mem_pkg::op_lhu: ext_data = {16'd0, half_sel};
         mem_pkg::op_lw:  ext_data = ram_dout;
         default:         ext_data = '0; // Stores
      endcase
   end

   always_comb begin
      rsp.valid      = valid_q;
      rsp.misaligned = mis_q;
      rsp.rdata      = load_q ? ext_data : '0;
   end

   // A misaligned response is still a valid one and carries no data
   a_mis_rsp_clean: assert property (
      @(posedge clk) disable iff (reset)
      rsp.misaligned |-> (rsp.valid && (rsp.rdata == '0))
   ) else $error("load_extract: misaligned response with valid %b, rdata 0x%0h",
                 rsp.valid, rsp.rdata);

endmodule

//--- source/mem_pkg.sv
// Shared types for the data memory block
// Operation enum, request and response structs, data width constants
package mem_pkg;

   // Word and lane geometry, fixed by the 32-bit operation set
   localparam int DATA_W  = 32;
   localparam int COL_W   = 8;
   localparam int NUM_COL = DATA_W / COL_W;

   // Load/store operations from the core
   typedef enum logic [2:0] {
      op_lb  = 3'd0, // Load byte, sign extended
      op_lh  = 3'd1, // Load halfword, sign extended
      op_lw  = 3'd2,
      op_lbu = 3'd3, // Load byte, zero extended
      op_lhu = 3'd4, // Load halfword, zero extended
      op_sb  = 3'd5,
      op_sh  = 3'd6,
      op_sw  = 3'd7
   } mem_op_t;

   // One request from the load/store stage
   typedef struct packed {
      mem_op_t             op;
      logic [31:0]         addr;  // Byte address
      logic [DATA_W-1:0]   wdata; // Store data, low-aligned
   } mem_req_t;

   // One response, one cycle after the request
   typedef struct packed {
      logic                valid;
      logic                misaligned;
      logic [DATA_W-1:0]   rdata; // Zero for stores and misaligned accesses
   } mem_rsp_t;

endpackage

//--- source/sp_ram_be.sv
// Word-wide byte-enabled single-port RAM
// One byte column per lane, read-first
module sp_ram_be #(
   parameter int ADDR_W = 10
) (
   input  logic                        clk,
   input  logic                        en,
   input  logic [mem_pkg::NUM_COL-1:0] we,
   input  logic [ADDR_W-1:0]           addr,
   input  logic [mem_pkg::DATA_W-1:0]  din,
   output logic [mem_pkg::DATA_W-1:0]  dout
);

   // Lane k holds byte k of every word
   for (genvar i = 0; i < mem_pkg::NUM_COL; i++) begin : g_col
      byte_col_ram #(
         .ADDR_W (ADDR_W)
      ) u_col (
         .clk  (clk),
         .en   (en),
         .we   (we[i]),                                     // Own write bit per lane
         .addr (addr),
         .din  (din[i*mem_pkg::COL_W +: mem_pkg::COL_W]),
         .dout (dout[i*mem_pkg::COL_W +: mem_pkg::COL_W])
      );
   end

   // A lane write without the shared enable would be dropped by every column
   a_we_needs_en: assert property (
      @(posedge clk) !en |-> (we == '0)
   ) else $error("sp_ram_be: write enable 0x%0h with en low", we);

endmodule

//--- source/store_align.sv
// Request decoder for the data RAM
// Alignment check, lane enables and store data placement
module store_align #(
   parameter int ADDR_W = 10
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req_valid,
   input  mem_pkg::mem_req_t           req,
   output logic                        ram_en,
   output logic [mem_pkg::NUM_COL-1:0] ram_we,
   output logic [ADDR_W-1:0]           ram_addr,
   output logic [mem_pkg::DATA_W-1:0]  ram_din,
   output logic                        misaligned
);

   typedef enum logic [1:0] {
      sz_byte,
      sz_half,
      sz_word
   } size_t;

   size_t                       size;
   logic                        is_store;
   logic [1:0]                  off;
   logic [mem_pkg::NUM_COL-1:0] lane_mask;

   assign off = req.addr[1:0];

   // Access size and direction from the op
   always_comb begin
      size     = sz_word;
      is_store = 1'b0;
      case (req.op)
         mem_pkg::op_lb,
         mem_pkg::op_lbu: size = sz_byte;
         mem_pkg::op_lh,
         mem_pkg::op_lhu: size = sz_half;
         mem_pkg::op_sb: begin
            size     = sz_byte;
            is_store = 1'b1;
         end
         mem_pkg::op_sh: begin
            size     = sz_half;
            is_store = 1'b1;
         end
         mem_pkg::op_sw: is_store = 1'b1;
         default: size = sz_word; // op_lw
      endcase
   end

   // Lanes, replicated data and alignment per size
   always_comb begin
      case (size)
         sz_byte: begin
            lane_mask  = 4'b0001 << off;
            ram_din    = {4{req.wdata[7:0]}};  // Byte on every lane
            misaligned = 1'b0;
         end
         sz_half: begin
            lane_mask  = 4'b0011 << off;
            ram_din    = {2{req.wdata[15:0]}}; // Both halves
            misaligned = off[0];
         end
         default: begin
            lane_mask  = 4'b1111;
            ram_din    = req.wdata;
            misaligned = |off;
         end
      endcase
   end

   assign ram_en   = req_valid && !misaligned; // No RAM access at all when misaligned
   assign ram_we   = (ram_en && is_store) ? lane_mask : '0;
   assign ram_addr = req.addr[ADDR_W+1:2];    // Word index

   // Lane pattern must agree with the store size and cover the addressed byte
   a_we_lanes: assert property (
      @(posedge clk) disable iff (reset)
      (ram_we != '0) |->
         ram_we[req.addr[1:0]] &&
         ((req.op == mem_pkg::op_sb && $onehot(ram_we)) ||
          (req.op == mem_pkg::op_sh && (ram_we == 4'b0011 || ram_we == 4'b1100)) ||
          (req.op == mem_pkg::op_sw && ram_we == 4'b1111))
   ) else $error("store_align: lanes 0x%0h do not fit op %s", ram_we, req.op.name());

endmodule
